// File: source/tile_cfg_pkg.sv
//##################################################
// Tile configuration: bus widths, slave indices,
// address map, adapter registers and boot ROM
//##################################################
package tile_cfg_pkg;

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int SEL_W      = DATA_W / 8;

   // Master 0 is the host port, master 1 the NoC adapter
   localparam int NR_MASTERS = 2;
   localparam int NR_SLAVES  = 3;

   localparam int SLAVE_MEM  = 0;
   localparam int SLAVE_NA   = 1;
   localparam int SLAVE_BOOT = 2;

   // Matched against address bits 31:28
   localparam logic [3:0] MATCH_MEM  = 4'h0;
   localparam logic [3:0] MATCH_NA   = 4'hE;
   localparam logic [3:0] MATCH_BOOT = 4'hF;

   // Adapter register word offsets
   localparam int NA_REG_FLIT  = 0;
   localparam int NA_REG_LAST  = 1;
   localparam int NA_REG_COUNT = 2;

   localparam int BOOT_WORDS = 16;
   localparam logic [DATA_W-1:0] BOOT_BASE = 32'hB007_0000;  // Word i reads BOOT_BASE + i

endpackage

// File: source/noc_pkg.sv
//##################################################
// NoC flit width, header layout and flit union
//##################################################
package noc_pkg;

   localparam int FLIT_W = 32;

   typedef struct packed {
      logic [4:0]  dest_tile;  // Destination tile id
      logic [2:0]  pkt_class;
      logic [23:0] word_addr;  // SRAM word address of first payload
   } noc_hdr_t;

   // First flit of a packet reads as a header, the rest as payload
   typedef union packed {
      noc_hdr_t          hdr;
      logic [FLIT_W-1:0] payload;
   } noc_flit_t;

endpackage

// File: source/wb_if.sv
//##################################################
// Wishbone-style bus with master and slave modports
//##################################################
`timescale 1ns/10ps

interface wb_if;

   logic                              cyc;
   logic                              stb;
   logic                              we;
   logic [tile_cfg_pkg::ADDR_W-1:0]   adr;
   logic [tile_cfg_pkg::DATA_W-1:0]   dat_w;  // Master to slave
   logic [tile_cfg_pkg::SEL_W-1:0]    sel;
   logic                              ack;    // One-cycle pulse
   logic [tile_cfg_pkg::DATA_W-1:0]   dat_r;  // Slave to master

   modport mst (
      output cyc, stb, we, adr, dat_w, sel,
      input  ack, dat_r
   );

   modport slv (
      input  cyc, stb, we, adr, dat_w, sel,
      output ack, dat_r
   );

endinterface

// File: source/bus_arbiter.sv
//##################################################
// Round-robin bus arbiter with address decode
// Answers unmapped accesses with zero data
//##################################################
`timescale 1ns/10ps

module bus_arbiter (
   input  logic clk,
   input  logic rst_n_i,
   wb_if.slv    m_i [tile_cfg_pkg::NR_MASTERS],
   wb_if.mst    s_o [tile_cfg_pkg::NR_SLAVES]
);

   localparam int NM    = tile_cfg_pkg::NR_MASTERS;
   localparam int NS    = tile_cfg_pkg::NR_SLAVES;
   localparam int IDX_W = (NM > 1) ? $clog2(NM) : 1;

   logic [NM-1:0]                   m_cyc;
   logic [NM-1:0]                   m_stb;
   logic [NM-1:0]                   m_we;
   logic [tile_cfg_pkg::ADDR_W-1:0] m_adr [NM];
   logic [tile_cfg_pkg::DATA_W-1:0] m_dat [NM];
   logic [tile_cfg_pkg::SEL_W-1:0]  m_sel [NM];
   logic [NS-1:0]                   s_ack;
   logic [tile_cfg_pkg::DATA_W-1:0] s_dat [NS];

   logic                            gnt_vld;
   logic [IDX_W-1:0]                gnt_idx;  // Also the round-robin pointer
   logic                            nxt_vld;
   logic [IDX_W-1:0]                nxt_idx;
   logic                            bus_cyc;
   logic                            bus_stb;
   logic [3:0]                      nib;
   logic [NS-1:0]                   hit;
   logic                            um_ack;
   logic                            resp_ack;
   logic [tile_cfg_pkg::DATA_W-1:0] resp_dat;

   // First requester after the last granted master wins
   always_comb begin
      int idx;
      nxt_vld = 1'b0;
      nxt_idx = gnt_idx;
      for (int k = NM; k >= 1; k--) begin
         idx = (int'(gnt_idx) + k) % NM;
         if (m_cyc[idx]) begin
            nxt_vld = 1'b1;
            nxt_idx = IDX_W'(idx);
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gnt_vld <= 1'b0;
         gnt_idx <= '0;
         um_ack  <= 1'b0;
      end else begin
         if (!gnt_vld || !m_cyc[gnt_idx]) begin  // Released once cyc drops
            gnt_vld <= nxt_vld;
            if (nxt_vld) gnt_idx <= nxt_idx;
         end
         um_ack <= bus_stb & ~|hit & ~um_ack;
      end
   end

   assign bus_cyc = gnt_vld & m_cyc[gnt_idx];
   assign bus_stb = bus_cyc & m_stb[gnt_idx];
   assign nib     = m_adr[gnt_idx][31:28];

   always_comb begin
      hit = '0;
      hit[tile_cfg_pkg::SLAVE_MEM]  = (nib == tile_cfg_pkg::MATCH_MEM);
      hit[tile_cfg_pkg::SLAVE_NA]   = (nib == tile_cfg_pkg::MATCH_NA);
      hit[tile_cfg_pkg::SLAVE_BOOT] = (nib == tile_cfg_pkg::MATCH_BOOT);
   end

   // Unmapped response is zero data
   always_comb begin
      resp_ack = um_ack;
      resp_dat = '0;
      for (int s = 0; s < NS; s++) begin
         if (hit[s]) begin
            resp_ack = resp_ack | s_ack[s];
            resp_dat = s_dat[s];
         end
      end
   end

   for (genvar m = 0; m < NM; m++) begin : g_mst
      assign m_cyc[m]      = m_i[m].cyc;
      assign m_stb[m]      = m_i[m].stb;
      assign m_we[m]       = m_i[m].we;
      assign m_adr[m]      = m_i[m].adr;
      assign m_dat[m]      = m_i[m].dat_w;
      assign m_sel[m]      = m_i[m].sel;
      assign m_i[m].ack    = resp_ack & gnt_vld & (gnt_idx == IDX_W'(m));
      assign m_i[m].dat_r  = resp_dat;
   end

   for (genvar s = 0; s < NS; s++) begin : g_slv
      assign s_o[s].cyc   = bus_cyc & hit[s];
      assign s_o[s].stb   = bus_stb & hit[s];  // Strobe only the decoded slave
      assign s_o[s].we    = m_we[gnt_idx];
      assign s_o[s].adr   = m_adr[gnt_idx];
      assign s_o[s].dat_w = m_dat[gnt_idx];
      assign s_o[s].sel   = m_sel[gnt_idx];
      assign s_ack[s]     = s_o[s].ack;
      assign s_dat[s]     = s_o[s].dat_r;
   end

endmodule

// File: source/local_sram.sv
//##################################################
// Local SRAM, word array with byte selects
//##################################################
`timescale 1ns/10ps

module local_sram #(
   parameter int MEM_WORDS = 256
) (
   input  logic clk,
   input  logic rst_n_i,
   wb_if.slv    bus_i
);

   localparam int AW = $clog2(MEM_WORDS);

   logic [tile_cfg_pkg::DATA_W-1:0] mem [MEM_WORDS];
   logic [AW-1:0]                   idx;
   logic                            req;

   assign idx = bus_i.adr[AW+1:2];  // Above the byte offset
   assign req = bus_i.cyc & bus_i.stb & ~bus_i.ack;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) bus_i.ack <= 1'b0;
      else          bus_i.ack <= req;
   end

   always_ff @(posedge clk) begin
      if (req && bus_i.we) begin
         for (int b = 0; b < tile_cfg_pkg::SEL_W; b++) begin
            if (bus_i.sel[b]) mem[idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
         end
      end
      bus_i.dat_r <= mem[idx];  // Valid with the ack
   end

endmodule

// File: source/boot_rom.sv
//##################################################
// Boot ROM, computed read-only words
//##################################################
`timescale 1ns/10ps

module boot_rom (
   input  logic clk,
   input  logic rst_n_i,
   wb_if.slv    bus_i
);

   logic [25:0] idx;
   logic        req;

   assign idx = bus_i.adr[27:2];  // Word index inside the slave window
   assign req = bus_i.cyc & bus_i.stb & ~bus_i.ack;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) bus_i.ack <= 1'b0;
      else          bus_i.ack <= req;  // Writes acked too, data dropped
   end

   always_ff @(posedge clk) begin
      if (bus_i.we || idx >= tile_cfg_pkg::BOOT_WORDS) bus_i.dat_r <= '0;
      else bus_i.dat_r <= tile_cfg_pkg::BOOT_BASE + tile_cfg_pkg::DATA_W'(idx);
   end

endmodule

// File: source/noc_adapter.sv
//##################################################
// NoC adapter: inbound packet writer as bus master,
// outbound flit register and packet count as slave
//##################################################
`timescale 1ns/10ps

module noc_adapter #(
   parameter int TILE_ID = 3
) (
   input  logic               clk,
   input  logic               rst_n_i,
   wb_if.slv                  reg_i,
   wb_if.mst                  dma_o,
   input  noc_pkg::noc_flit_t noc_in_flit_i,
   input  logic               noc_in_last_i,
   input  logic               noc_in_valid_i,
   output logic               noc_in_ready_o,
   output noc_pkg::noc_flit_t noc_out_flit_o,
   output logic               noc_out_last_o,
   output logic               noc_out_valid_o,
   input  logic               noc_out_ready_i
);

   typedef enum logic [1:0] {ST_HDR, ST_PAY, ST_DROP} in_state_t;

   in_state_t                         state;
   logic                              wr_pend;  // Bus write of a payload word open
   logic [23:0]                       wr_ptr;
   logic [noc_pkg::FLIT_W-1:0]        wr_dat;
   logic                              in_acc;
   logic [tile_cfg_pkg::DATA_W-1:0]   pkt_cnt;
   logic [1:0]                        reg_off;
   logic                              reg_req;
   logic                              flit_wr;
   logic                              rd_ack;

   // Inbound path
   assign noc_in_ready_o = ~wr_pend;
   assign in_acc         = noc_in_valid_i & ~wr_pend;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state   <= ST_HDR;
         wr_pend <= 1'b0;
         wr_ptr  <= '0;
         pkt_cnt <= '0;
      end else begin
         if (wr_pend && dma_o.ack) begin
            wr_pend <= 1'b0;
            wr_ptr  <= wr_ptr + 24'd1;
         end
         if (in_acc) begin
            case (state)
               ST_HDR: begin
                  if (noc_in_flit_i.hdr.dest_tile == 5'(TILE_ID)) begin
                     wr_ptr <= noc_in_flit_i.hdr.word_addr;
                     if (noc_in_last_i) pkt_cnt <= pkt_cnt + 1'b1;  // Header-only packet
                     else               state   <= ST_PAY;
                  end else if (!noc_in_last_i) begin
                     state <= ST_DROP;  // Not ours, swallow the rest
                  end
               end
               ST_PAY: begin
                  wr_pend <= 1'b1;
                  if (noc_in_last_i) begin
                     state   <= ST_HDR;
                     pkt_cnt <= pkt_cnt + 1'b1;
                  end
               end
               default: begin
                  if (noc_in_last_i) state <= ST_HDR;
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_acc && state == ST_PAY) wr_dat <= noc_in_flit_i.payload;
   end

   assign dma_o.cyc   = wr_pend;
   assign dma_o.stb   = wr_pend;
   assign dma_o.we    = 1'b1;
   assign dma_o.adr   = tile_cfg_pkg::ADDR_W'({wr_ptr, 2'b00});  // SRAM window
   assign dma_o.dat_w = wr_dat;
   assign dma_o.sel   = '1;

   // Register side
   assign reg_off = reg_i.adr[3:2];
   assign reg_req = reg_i.cyc & reg_i.stb;
   assign flit_wr = reg_req & reg_i.we &
                    (reg_off == 2'(tile_cfg_pkg::NA_REG_FLIT) ||
                     reg_off == 2'(tile_cfg_pkg::NA_REG_LAST));

   // Flit write is acked on the edge the flit leaves
   assign reg_i.ack = rd_ack | (flit_wr & noc_out_valid_o & noc_out_ready_i);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_ack          <= 1'b0;
         noc_out_valid_o <= 1'b0;
      end else begin
         rd_ack <= reg_req & ~flit_wr & ~rd_ack;
         if (flit_wr && !noc_out_valid_o)           noc_out_valid_o <= 1'b1;
         else if (noc_out_valid_o && noc_out_ready_i) noc_out_valid_o <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (flit_wr && !noc_out_valid_o) begin
         noc_out_flit_o.payload <= reg_i.dat_w;
         noc_out_last_o         <= (reg_off == 2'(tile_cfg_pkg::NA_REG_LAST));
      end
      reg_i.dat_r <= (reg_off == 2'(tile_cfg_pkg::NA_REG_COUNT)) ? pkt_cnt : '0;
   end

endmodule

// File: source/compute_tile.sv
//##################################################
// Compute tile top: host port, bus arbiter, SRAM,
// boot ROM and NoC adapter
//##################################################
`timescale 1ns/10ps

module compute_tile #(
   parameter int TILE_ID   = 3,
   parameter int MEM_WORDS = 256
) (
   input  logic                              clk,
   input  logic                              rst_n_i,

   input  logic                              host_cyc_i,
   input  logic                              host_stb_i,
   input  logic                              host_we_i,
   input  logic [tile_cfg_pkg::ADDR_W-1:0]   host_adr_i,
   input  logic [tile_cfg_pkg::DATA_W-1:0]   host_dat_i,
   input  logic [tile_cfg_pkg::SEL_W-1:0]    host_sel_i,
   output logic                              host_ack_o,
   output logic [tile_cfg_pkg::DATA_W-1:0]   host_dat_o,

   input  noc_pkg::noc_flit_t                noc_in_flit_i,
   input  logic                              noc_in_last_i,
   input  logic                              noc_in_valid_i,
   output logic                              noc_in_ready_o,
   output noc_pkg::noc_flit_t                noc_out_flit_o,
   output logic                              noc_out_last_o,
   output logic                              noc_out_valid_o,
   input  logic                              noc_out_ready_i
);

   localparam int MST_HOST = 0;
   localparam int MST_NA   = 1;

   wb_if m_bus [tile_cfg_pkg::NR_MASTERS] ();  // Host, adapter inbound
   wb_if s_bus [tile_cfg_pkg::NR_SLAVES] ();   // SRAM, adapter regs, boot ROM

   assign m_bus[MST_HOST].cyc   = host_cyc_i;
   assign m_bus[MST_HOST].stb   = host_stb_i;
   assign m_bus[MST_HOST].we    = host_we_i;
   assign m_bus[MST_HOST].adr   = host_adr_i;
   assign m_bus[MST_HOST].dat_w = host_dat_i;
   assign m_bus[MST_HOST].sel   = host_sel_i;
   assign host_ack_o            = m_bus[MST_HOST].ack;
   assign host_dat_o            = m_bus[MST_HOST].dat_r;

   bus_arbiter u_bus (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .m_i     (m_bus),
      .s_o     (s_bus)
   );

   local_sram #(.MEM_WORDS(MEM_WORDS)) u_ram (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus_i   (s_bus[tile_cfg_pkg::SLAVE_MEM])
   );

   boot_rom u_bootrom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus_i   (s_bus[tile_cfg_pkg::SLAVE_BOOT])
   );

   noc_adapter #(.TILE_ID(TILE_ID)) u_na (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .reg_i           (s_bus[tile_cfg_pkg::SLAVE_NA]),
      .dma_o           (m_bus[MST_NA]),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_last_i   (noc_in_last_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_last_o  (noc_out_last_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i)
   );

endmodule

// File: verif/tile_assert.sv
//##################################################
// Bound assertions on the compute tile ports
//##################################################
`timescale 1ns/10ps

module tile_assert (
   input logic               clk,
   input logic               rst_n_i,
   input logic               host_cyc_i,
   input logic               host_ack_o,
   input noc_pkg::noc_flit_t noc_out_flit_o,
   input logic               noc_out_last_o,
   input logic               noc_out_valid_o,
   input logic               noc_out_ready_i,
   input logic               noc_in_ready_o
);

   int unsigned fail_cnt = 0;  // Assertion failures seen

   ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
      host_ack_o |-> host_cyc_i)
   else begin
      fail_cnt++;
      $error("host_ack_o high outside a host bus cycle");
   end

   out_flit_held: assert property (@(posedge clk) disable iff (!rst_n_i)
      noc_out_valid_o && !noc_out_ready_i |=>
      noc_out_valid_o && $stable(noc_out_flit_o) && $stable(noc_out_last_o))
   else begin
      fail_cnt++;
      $error("Outbound flit changed or dropped before acceptance");
   end

   reset_values: assert property (@(posedge clk)
      !rst_n_i |-> noc_in_ready_o && !noc_out_valid_o)
   else begin
      fail_cnt++;
      $error("NoC handshake outputs not at reset values during reset");
   end

endmodule

bind compute_tile tile_assert u_chk (.*);

// File: verif/tb_compute_tile.sv
//##################################################
// Compute tile testbench: clock, reset, stimulus
// table, NoC drivers, checks and timeout
//##################################################
`timescale 1ns/10ps

module tb_compute_tile;

   typedef enum logic [2:0] {K_WR, K_RD, K_SEND, K_PAY, K_WAIT, K_FWR, K_FLIT} kind_t;

   typedef struct packed {
      kind_t       kind;
      logic [31:0] adr;
      logic [31:0] dat;   // Write data, header or expected flit
      logic [3:0]  sel;
      logic [31:0] exp;   // Read data, payload count, flit count or last bit
   } entry_t;

   localparam int          TILE_ID  = 3;
   localparam logic [31:0] NA_BASE  = 32'hE000_0000;
   localparam logic [31:0] ROM_BASE = 32'hF000_0000;

   logic               clk = 1'b0;
   logic               rst_n_i;
   logic               host_cyc_i;
   logic               host_stb_i;
   logic               host_we_i;
   logic [31:0]        host_adr_i;
   logic [31:0]        host_dat_i;
   logic [3:0]         host_sel_i;
   logic               host_ack_o;
   logic [31:0]        host_dat_o;
   noc_pkg::noc_flit_t noc_in_flit_i = '0;
   logic               noc_in_last_i = 1'b0;
   logic               noc_in_valid_i = 1'b0;
   logic               noc_in_ready_o;
   noc_pkg::noc_flit_t noc_out_flit_o;
   logic               noc_out_last_o;
   logic               noc_out_valid_o;
   logic               noc_out_ready_i = 1'b0;

   entry_t             tbl [$];
   logic [32:0]        in_q [$];   // {last, flit} waiting to be sent
   logic [32:0]        out_q [$];  // {last, flit} seen leaving the tile
   logic [31:0]        model [int];
   logic [31:0]        rng = 32'd70;
   logic [31:0]        stall_rng = 32'd70;
   logic               in_took = 1'b0;
   int unsigned        cyc_cnt = 0;

   compute_tile #(.TILE_ID(TILE_ID), .MEM_WORDS(256)) UUT (.*);

   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, wr, input logic [3:0] sel);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++)
         if (sel[b]) res[8*b +: 8] = wr[8*b +: 8];
      return res;
   endfunction

   function automatic logic [31:0] hdr_word(input logic [4:0] dest, input logic [23:0] waddr);
      return {dest, 3'd1, waddr};  // dest_tile, pkt_class, word_addr
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_val(input string name, input logic [31:0] act, exp);
      if (act !== exp) abort_run($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, act, exp));
   endtask

   task automatic add_entry(input kind_t kind, input logic [31:0] adr, dat,
                            input logic [3:0] sel, input logic [31:0] exp);
      tbl.push_back(entry_t'{kind, adr, dat, sel, exp});
   endtask

   task automatic sram_write(input int word, input logic [31:0] dat, input logic [3:0] sel);
      logic [31:0] old;
      old = model.exists(word) ? model[word] : 32'h0;
      model[word] = merge_bytes(old, dat, sel);
      add_entry(K_WR, 32'(word) << 2, dat, sel, '0);
   endtask

   task automatic sram_read(input int word);
      add_entry(K_RD, 32'(word) << 2, '0, '0, model[word]);
   endtask

   task automatic count_read(input int cnt);
      add_entry(K_RD, NA_BASE + 32'(tile_cfg_pkg::NA_REG_COUNT * 4), '0, '0, 32'(cnt));
   endtask

   task automatic add_packet(input logic [4:0] dest, input logic [23:0] waddr, input int n);
      add_entry(K_SEND, '0, hdr_word(dest, waddr), '0, 32'(n));
      for (int p = 0; p < n; p++) begin
         rng = xorshift32(rng);
         add_entry(K_PAY, '0, rng, '0, '0);
         if (dest == 5'(TILE_ID)) model[int'(waddr) + p] = rng;  // Only ours land in SRAM
      end
   endtask

   task automatic build_table();
      logic [31:0] flit [3];
      for (int w = 0; w < 20; w += 3)
         add_entry(K_RD, ROM_BASE + 32'(w * 4), '0, '0,
                   (w < tile_cfg_pkg::BOOT_WORDS) ? tile_cfg_pkg::BOOT_BASE + 32'(w) : '0);
      add_entry(K_RD, ROM_BASE + 32'(tile_cfg_pkg::BOOT_WORDS * 4), '0, '0, '0);
      for (int w = 4; w < 6; w++) begin
         rng = xorshift32(rng);
         sram_write(w, rng, 4'hF);
      end
      sram_write(4, 32'hA1B2_C3D4, 4'b0101);
      sram_write(5, 32'h1122_3344, 4'b1000);
      sram_write(5, 32'h5566_7788, 4'b0010);
      sram_read(4);
      sram_read(5);
      count_read(0);
      add_packet(5'(TILE_ID), 24'h40, 3);
      add_entry(K_RD, ROM_BASE + 32'd8, '0, '0, tile_cfg_pkg::BOOT_BASE + 32'd2);  // Races the DMA
      sram_read(4);
      add_entry(K_RD, ROM_BASE + 32'd36, '0, '0, tile_cfg_pkg::BOOT_BASE + 32'd9);
      add_entry(K_WAIT, '0, '0, '0, '0);
      for (int w = 'h40; w < 'h43; w++) sram_read(w);
      count_read(1);
      add_packet(5'd7, 24'h40, 3);  // Other tile, same words
      add_entry(K_WAIT, '0, '0, '0, '0);
      for (int w = 'h40; w < 'h43; w++) sram_read(w);
      count_read(1);
      for (int f = 0; f < 3; f++) begin
         rng = xorshift32(rng);
         flit[f] = rng;
         add_entry(K_FWR, NA_BASE + 32'((f == 2 ? tile_cfg_pkg::NA_REG_LAST :
                   tile_cfg_pkg::NA_REG_FLIT) * 4), rng, 4'hF, 32'(f + 1));
      end
      for (int f = 0; f < 3; f++) add_entry(K_FLIT, '0, flit[f], '0, 32'(f == 2));
      add_entry(K_RD, 32'h5000_0010, '0, '0, '0);  // Unmapped nibble
   endtask

   task automatic host_access(input logic we, input logic [31:0] adr, dat,
                              input logic [3:0] sel, output logic [31:0] rdat);
      @(negedge clk);
      host_cyc_i = 1'b1;
      host_stb_i = 1'b1;
      host_we_i  = we;
      host_adr_i = adr;
      host_dat_i = dat;
      host_sel_i = sel;
      do @(posedge clk); while (!host_ack_o);  // Transfer ends on the ack edge
      rdat = host_dat_o;
      @(negedge clk);
      host_cyc_i = 1'b0;
      host_stb_i = 1'b0;
      host_we_i  = 1'b0;
   endtask

   // Queue drained and the last DMA write acknowledged
   task automatic wait_inbound();
      do @(posedge clk); while (in_q.size() != 0 || noc_in_valid_i || !noc_in_ready_o);
   endtask

   always @(posedge clk) in_took <= noc_in_valid_i & noc_in_ready_o;

   always @(negedge clk) begin
      if (in_took) void'(in_q.pop_front());
      if (in_q.size() != 0) begin
         noc_in_valid_i = 1'b1;
         noc_in_flit_i  = in_q[0][31:0];
         noc_in_last_i  = in_q[0][32];
      end else begin
         noc_in_valid_i = 1'b0;
         noc_in_last_i  = 1'b0;
      end
   end

   always @(negedge clk) begin
      stall_rng = xorshift32(stall_rng);
      noc_out_ready_i = stall_rng[3];  // Random back-pressure
   end

   always @(posedge clk) begin
      if (rst_n_i && noc_out_valid_o && noc_out_ready_i)
         out_q.push_back({noc_out_last_o, noc_out_flit_o});
   end

   always @(posedge clk) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt > 32'(tbl.size()) * 64 + 20)
         abort_run($sformatf("Timeout: the run did not finish within %0d cycles", cyc_cnt));
   end

   initial begin
      logic [31:0] rd;
      logic [32:0] got;
      int          n;
      rst_n_i    = 1'b0;
      host_cyc_i = 1'b0;
      host_stb_i = 1'b0;
      host_we_i  = 1'b0;
      host_adr_i = '0;
      host_dat_i = '0;
      host_sel_i = '0;
      build_table();
      repeat (10) @(negedge clk);
      rst_n_i = 1'b1;
      for (int i = 0; i < tbl.size(); i++) begin
         case (tbl[i].kind)
            K_WR: host_access(1'b1, tbl[i].adr, tbl[i].dat, tbl[i].sel, rd);
            K_RD: begin
               host_access(1'b0, tbl[i].adr, '0, 4'hF, rd);
               check_val("host_dat_o", rd, tbl[i].exp);
            end
            K_SEND: begin
               n = int'(tbl[i].exp);
               in_q.push_back({n == 0, tbl[i].dat});
               for (int p = 1; p <= n; p++) in_q.push_back({p == n, tbl[i + p].dat});
               i += n;  // Payload entries consumed here
            end
            K_WAIT: wait_inbound();
            K_FWR: begin
               host_access(1'b1, tbl[i].adr, tbl[i].dat, tbl[i].sel, rd);
               check_val("outbound flit count", 32'(out_q.size()), tbl[i].exp);
            end
            K_FLIT: begin
               if (out_q.size() == 0) begin
                  abort_run("No outbound flit left the tile");
               end else begin
                  got = out_q.pop_front();
                  check_val("noc_out_flit_o", got[31:0], tbl[i].dat);
                  check_val("noc_out_last_o", 32'(got[32]), tbl[i].exp);
               end
            end
            default: abort_run("Stimulus table holds an entry of an unknown kind");
         endcase
      end
      if (UUT.u_chk.fail_cnt == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         abort_run("Assertion failures were seen during the run");
      end
   end

endmodule

// File: vlog.f
source/tile_cfg_pkg.sv
source/noc_pkg.sv
source/wb_if.sv
source/bus_arbiter.sv
source/local_sram.sv
source/boot_rom.sv
source/noc_adapter.sv
source/compute_tile.sv
verif/tile_assert.sv
verif/tb_compute_tile.sv

// File: Makefile
TOP  := tb_compute_tile
SRCS := $(wildcard source/*.sv verif/*.sv)

.PHONY: run clean

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "Simulation did not pass"; exit 1; \
	fi

obj_dir/V$(TOP): vlog.f $(SRCS)
	verilator --binary --assert -Wno-fatal -j 0 --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir sim.log
